//--- design/char_engine.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debug screen text engine, renders CPU state into a byte-wide frame buffer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module char_engine (
	input logic clock,
	input logic reset,
	output logic [4:0] reg_sel,
	input screen_pkg::reg_word_t reg_data,	// Combinational from reg_sel
	input screen_pkg::pc_word_t cycle_count,
	input logic pc_strobe,
	input screen_pkg::pc_word_t pc_value,
	output logic mem_valid,
	input logic mem_ready,
	output screen_pkg::fb_addr_t mem_addr,
	output char_pkg::glyph_row_t mem_data
);

	logic [3:0] hist_index;
	screen_pkg::pc_word_t hist_value;
	logic char_valid;
	logic char_ready;
	char_pkg::char_code_t char_code;
	screen_pkg::text_row_t char_row;
	screen_pkg::text_col_t char_col;
	char_pkg::char_code_t glyph_code;
	char_pkg::glyph_t glyph_rows;

	field_sequencer u_sequencer (
		.clock(clock),
		.reset(reset),
		.reg_sel(reg_sel),
		.reg_data(reg_data),
		.cycle_count(cycle_count),
		.hist_index(hist_index),
		.hist_value(hist_value),
		.char_valid(char_valid),
		.char_ready(char_ready),
		.char_code(char_code),
		.char_row(char_row),
		.char_col(char_col)
	);

	pc_history u_history (
		.clock(clock),
		.reset(reset),
		.pc_strobe(pc_strobe),
		.pc_value(pc_value),
		.hist_index(hist_index),
		.hist_value(hist_value)
	);

	char_writer u_writer (
		.clock(clock),
		.reset(reset),
		.char_valid(char_valid),
		.char_ready(char_ready),
		.char_code(char_code),
		.char_row(char_row),
		.char_col(char_col),
		.glyph_code(glyph_code),
		.glyph_rows(glyph_rows),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

	glyph_rom u_rom (
		.glyph_code(glyph_code),
		.glyph_rows(glyph_rows)
	);

endmodule

//--- design/char_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character set codes, glyph geometry and the fixed label strings
// Shared by the glyph ROM, the field sequencer and the character writer
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package char_pkg;

	typedef logic [5:0] char_code_t;	// 0-F hex, G-Z letters, then symbols
	typedef logic [7:0] glyph_row_t;	// Bit 7 is the leftmost pixel

	localparam int GLYPH_ROWS = 8;

	typedef glyph_row_t [0:GLYPH_ROWS-1] glyph_t;	// Row 0 is the top row

	// Symbols follow the letter Z
	localparam char_code_t CHAR_SPACE = 6'h24;
	localparam char_code_t CHAR_FILLED = 6'h25;
	localparam char_code_t CHAR_DASH = 6'h26;
	localparam char_code_t CHAR_COLON = 6'h27;
	localparam char_code_t CHAR_PERIOD = 6'h28;

	localparam char_code_t CHAR_C = 6'h0C;	// Same code as hex digit C
	localparam char_code_t CHAR_E = 6'h0E;	// Same code as hex digit E
	localparam char_code_t CHAR_G = 6'h10;
	localparam char_code_t CHAR_H = 6'h11;
	localparam char_code_t CHAR_I = 6'h12;
	localparam char_code_t CHAR_L = 6'h15;
	localparam char_code_t CHAR_O = 6'h18;
	localparam char_code_t CHAR_P = 6'h19;
	localparam char_code_t CHAR_R = 6'h1B;
	localparam char_code_t CHAR_S = 6'h1C;
	localparam char_code_t CHAR_T = 6'h1D;
	localparam char_code_t CHAR_Y = 6'h22;

	// Label strings, padded with spaces to ten characters
	localparam char_code_t [0:9] LABEL_REGISTERS = {
		CHAR_R, CHAR_E, CHAR_G, CHAR_I, CHAR_S,
		CHAR_T, CHAR_E, CHAR_R, CHAR_S, CHAR_SPACE
	};

	localparam char_code_t [0:9] LABEL_PC_HISTORY = {
		CHAR_P, CHAR_C, CHAR_SPACE, CHAR_H, CHAR_I,
		CHAR_S, CHAR_T, CHAR_O, CHAR_R, CHAR_Y
	};

	localparam char_code_t [0:9] LABEL_CYCLES = {
		CHAR_C, CHAR_Y, CHAR_C, CHAR_L, CHAR_E,
		CHAR_S, CHAR_COLON, CHAR_SPACE, CHAR_SPACE, CHAR_SPACE
	};

endpackage

//--- design/char_writer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Expands one character into eight frame buffer byte writes, top line first
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module char_writer (
	input logic clock,
	input logic reset,
	input logic char_valid,
	output logic char_ready,
	input char_pkg::char_code_t char_code,
	input screen_pkg::text_row_t char_row,
	input screen_pkg::text_col_t char_col,
	output char_pkg::char_code_t glyph_code,
	input char_pkg::glyph_t glyph_rows,
	output logic mem_valid,
	input logic mem_ready,
	output screen_pkg::fb_addr_t mem_addr,
	output char_pkg::glyph_row_t mem_data
);

	char_pkg::char_code_t code_q;
	screen_pkg::text_row_t row_q;
	screen_pkg::text_col_t col_q;
	logic [$clog2(char_pkg::GLYPH_ROWS)-1:0] line_q;

	// One character in flight, busy while its bytes drain
	assign char_ready = !mem_valid;
	assign glyph_code = code_q;
	assign mem_data = glyph_rows[line_q];

	// row * pitch + (first line + glyph line) * line bytes + column
	assign mem_addr = screen_pkg::fb_addr_t'(row_q * screen_pkg::ROW_PITCH
		+ (screen_pkg::GLYPH_FIRST_LINE + line_q) * screen_pkg::LINE_BYTES
		+ col_q);

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_valid <= 1'b0;
			line_q <= '0;
		end else if (char_valid && char_ready) begin
			mem_valid <= 1'b1;
			line_q <= '0;
		end else if (mem_valid && mem_ready) begin
			if (line_q == char_pkg::GLYPH_ROWS - 1) begin
				mem_valid <= 1'b0;	// Eighth byte done
			end
			line_q <= line_q + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (char_valid && char_ready) begin
			code_q <= char_code;
			row_q <= char_row;
			col_q <= char_col;
		end
	end

endmodule

//--- design/field_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Draws the three labels once, then loops over the 32 line slots for ever
// Emits one character at a time with its text row and column
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module field_sequencer (
	input logic clock,
	input logic reset,
	output logic [4:0] reg_sel,
	input screen_pkg::reg_word_t reg_data,
	input screen_pkg::pc_word_t cycle_count,
	output logic [3:0] hist_index,
	input screen_pkg::pc_word_t hist_value,
	output logic char_valid,
	input logic char_ready,
	output char_pkg::char_code_t char_code,
	output screen_pkg::text_row_t char_row,
	output screen_pkg::text_col_t char_col
);

	logic emit;	// Low for the one set-up cycle of each field
	logic in_slots;
	logic [1:0] label_idx;
	logic [1:0] field;
	logic [4:0] slot;
	logic [3:0] char_idx;
	screen_pkg::reg_word_t word_q;	// Next nibble sits in the top four bits
	screen_pkg::text_row_t field_row;
	screen_pkg::text_col_t field_col;
	logic [3:0] field_len;
	char_pkg::char_code_t label_code;
	logic is_colon;
	logic last_char;
	logic pc_skip;
	logic advance;

	assign reg_sel = slot;	// Held for the whole slot
	assign hist_index = slot[3:0];
	assign char_valid = emit;
	assign advance = emit && char_ready;
	assign is_colon = in_slots && (field == screen_pkg::FIELD_DATA) && (char_idx == 4'd0);
	assign last_char = (char_idx == field_len - 4'd1);
	assign pc_skip = (slot >= screen_pkg::PC_HIST_DEPTH);
	assign char_row = field_row;
	assign char_col = field_col + screen_pkg::text_col_t'(char_idx);
	assign char_code = !in_slots ? label_code :
		is_colon ? char_pkg::CHAR_COLON : {2'b00, word_q[31:28]};

	// Position and length of the current field
	always_comb begin
		field_row = screen_pkg::REG_FIRST_ROW + screen_pkg::text_row_t'(slot);
		field_col = screen_pkg::REG_INDEX_COL;
		field_len = screen_pkg::INDEX_LEN;
		label_code = char_pkg::LABEL_REGISTERS[char_idx];
		if (!in_slots) begin
			field_row = screen_pkg::LABEL_ROW;
			case (label_idx)
				2'd0: begin
					field_col = screen_pkg::REGS_LABEL_COL;
					field_len = screen_pkg::REGS_LABEL_LEN;
				end
				2'd1: begin
					field_col = screen_pkg::PC_LABEL_COL;
					field_len = screen_pkg::PC_LABEL_LEN;
					label_code = char_pkg::LABEL_PC_HISTORY[char_idx];
				end
				default: begin
					field_row = screen_pkg::CYCLES_LABEL_ROW;
					field_col = screen_pkg::CYCLES_LABEL_COL;
					field_len = screen_pkg::CYCLES_LABEL_LEN;
					label_code = char_pkg::LABEL_CYCLES[char_idx];
				end
			endcase
		end else begin
			case (field)
				screen_pkg::FIELD_DATA: begin
					field_col = screen_pkg::REG_DATA_COL;
					field_len = screen_pkg::DATA_LEN;
				end
				screen_pkg::FIELD_CYCLES: begin
					field_row = screen_pkg::CYCLES_LABEL_ROW;	// Shares the label row
					field_col = screen_pkg::CYCLES_COL;
					field_len = screen_pkg::COUNT_LEN;
				end
				screen_pkg::FIELD_PC: begin
					field_col = screen_pkg::PC_HIST_COL;
					field_len = screen_pkg::COUNT_LEN;
				end
				default: field_col = screen_pkg::REG_INDEX_COL;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			emit <= 1'b0;
			in_slots <= 1'b0;
			label_idx <= '0;
			field <= screen_pkg::FIELD_INDEX;
			slot <= '0;
			char_idx <= '0;
		end else if (!emit) begin
			emit <= 1'b1;	// Word latched, start presenting
		end else if (advance) begin
			if (last_char) begin
				char_idx <= '0;
				emit <= 1'b0;
				if (!in_slots) begin
					label_idx <= label_idx + 2'd1;
					in_slots <= (label_idx == 2'd2);
				end else if ((field == screen_pkg::FIELD_PC) ||
					((field == screen_pkg::FIELD_CYCLES) && pc_skip)) begin
					field <= screen_pkg::FIELD_INDEX;
					slot <= (slot == screen_pkg::REG_COUNT - 1) ? '0 : slot + 5'd1;
				end else begin
					field <= field + 2'd1;
				end
			end else begin
				char_idx <= char_idx + 4'd1;
			end
		end
	end

	// Field word, sampled in the set-up cycle and shifted one nibble per digit
	always_ff @(posedge clock) begin
		if (!emit) begin
			case (field)
				screen_pkg::FIELD_INDEX: word_q <= {3'b000, slot, 24'h000000};
				screen_pkg::FIELD_DATA: word_q <= reg_data;
				screen_pkg::FIELD_CYCLES: word_q <= {cycle_count, 16'h0000};
				default: word_q <= {hist_value, 16'h0000};
			endcase
		end else if (advance && !is_colon) begin
			word_q <= {word_q[27:0], 4'h0};
		end
	end

endmodule

//--- design/glyph_rom.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Combinational glyph table, gives the eight pixel rows of a character code
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module glyph_rom (
	input char_pkg::char_code_t glyph_code,
	output char_pkg::glyph_t glyph_rows
);

	// Each constant lists the rows top first, one byte per row
	always_comb begin
		case (glyph_code)
			6'h00: glyph_rows = 64'h3C42_4242_4242_423C;	// 0
			6'h01: glyph_rows = 64'h1838_7818_1818_187E;
			6'h02: glyph_rows = 64'h3C66_660C_1830_607E;
			6'h03: glyph_rows = 64'h7C06_067C_0606_067C;
			6'h04: glyph_rows = 64'h0E16_2646_467E_0606;
			6'h05: glyph_rows = 64'h7E60_6078_0C06_0C78;
			6'h06: glyph_rows = 64'h3C40_407C_4242_423C;
			6'h07: glyph_rows = 64'h7E06_0606_0C18_3060;
			6'h08: glyph_rows = 64'h3C42_423C_4242_423C;
			6'h09: glyph_rows = 64'h3C46_4646_3E06_0606;
			6'h0A: glyph_rows = 64'h3C42_4242_7E42_4242;	// A
			6'h0B: glyph_rows = 64'h7C42_467C_4642_427C;
			6'h0C: glyph_rows = 64'h3E60_6060_6060_603E;
			6'h0D: glyph_rows = 64'h7C62_6262_6262_627C;
			6'h0E: glyph_rows = 64'h3E60_607E_6060_603E;
			6'h0F: glyph_rows = 64'h7E60_607E_6060_6060;	// F
			6'h10: glyph_rows = 64'h3C60_606E_6666_663C;	// G
			6'h11: glyph_rows = 64'h6666_667E_6666_6666;
			6'h12: glyph_rows = 64'h7E18_1818_1818_187E;
			6'h13: glyph_rows = 64'h7E06_0606_0606_663C;
			6'h14: glyph_rows = 64'h6666_6C70_706C_6666;
			6'h15: glyph_rows = 64'h6060_6060_6060_607E;	// L
			6'h16: glyph_rows = 64'h4266_5A5A_4242_4242;
			6'h17: glyph_rows = 64'h4242_6252_4A46_4242;
			6'h18: glyph_rows = 64'h3C42_4242_4242_423C;
			6'h19: glyph_rows = 64'h7C42_4242_7C60_6060;	// P
			6'h1A: glyph_rows = 64'h3C42_4242_4242_443A;
			6'h1B: glyph_rows = 64'h3C42_4242_7C58_4C46;
			6'h1C: glyph_rows = 64'h3C40_403C_0202_023C;
			6'h1D: glyph_rows = 64'h7E18_1818_1818_1818;	// T
			6'h1E: glyph_rows = 64'h4242_4242_4242_423C;
			6'h1F: glyph_rows = 64'h4242_4242_4242_2418;
			6'h20: glyph_rows = 64'h4242_4242_5A5A_6642;
			6'h21: glyph_rows = 64'h4242_2418_1824_4242;
			6'h22: glyph_rows = 64'h4242_4224_1818_1818;	// Y
			6'h23: glyph_rows = 64'h7E06_060C_3060_607E;	// Z
			char_pkg::CHAR_SPACE: glyph_rows = '0;
			char_pkg::CHAR_FILLED: glyph_rows = '1;	// Solid block
			char_pkg::CHAR_DASH: glyph_rows = 64'h0000_007E_0000_0000;
			char_pkg::CHAR_COLON: glyph_rows = 64'h0018_1800_0018_1800;
			char_pkg::CHAR_PERIOD: glyph_rows = 64'h0000_0000_0000_C0C0;
			default: glyph_rows = '0;	// Unused codes draw blank
		endcase
	end

endmodule

//--- design/pc_history.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Last ten distinct program counter values, newest at index 0
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module pc_history (
	input logic clock,
	input logic reset,
	input logic pc_strobe,
	input screen_pkg::pc_word_t pc_value,
	input logic [3:0] hist_index,
	output screen_pkg::pc_word_t hist_value
);

	screen_pkg::pc_word_t entries [screen_pkg::PC_HIST_DEPTH];

	// Push only on a change, so a CPU stalled on one address keeps its history
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < screen_pkg::PC_HIST_DEPTH; i++) begin
				entries[i] <= '0;
			end
		end else if (pc_strobe && (pc_value != entries[0])) begin
			entries[0] <= pc_value;
			for (int i = 1; i < screen_pkg::PC_HIST_DEPTH; i++) begin
				entries[i] <= entries[i-1];	// Oldest falls off the end
			end
		end
	end

	assign hist_value = (hist_index < screen_pkg::PC_HIST_DEPTH) ?
		entries[hist_index] : '0;

endmodule

//--- design/screen_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen geometry of the 640x480 frame buffer and where each field is drawn
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package screen_pkg;

	localparam int TEXT_COLS = 80;
	localparam int TEXT_ROWS = 48;
	localparam int CELL_LINES = 10;	// Scan lines per text row
	localparam int LINE_BYTES = TEXT_COLS;	// One byte per column
	localparam int ROW_PITCH = CELL_LINES * LINE_BYTES;
	localparam int GLYPH_FIRST_LINE = 1;	// Line 0 of a cell stays blank

	typedef logic [5:0] text_row_t;
	typedef logic [6:0] text_col_t;
	typedef logic [15:0] fb_addr_t;
	typedef logic [31:0] reg_word_t;
	typedef logic [15:0] pc_word_t;

	localparam int REG_COUNT = 32;
	localparam int PC_HIST_DEPTH = 10;

	localparam text_row_t LABEL_ROW = 6'd0;
	localparam text_row_t REG_FIRST_ROW = 6'd1;	// Register and PC rows start here
	localparam text_row_t CYCLES_LABEL_ROW = 6'd34;

	localparam text_col_t REG_INDEX_COL = 7'd0;
	localparam text_col_t REG_DATA_COL = 7'd2;
	localparam text_col_t CYCLES_COL = 7'd8;
	localparam text_col_t PC_HIST_COL = 7'd14;
	localparam text_col_t REGS_LABEL_COL = 7'd0;
	localparam text_col_t PC_LABEL_COL = 7'd14;
	localparam text_col_t CYCLES_LABEL_COL = 7'd0;

	// Characters per field
	localparam logic [3:0] REGS_LABEL_LEN = 4'd9;
	localparam logic [3:0] PC_LABEL_LEN = 4'd10;
	localparam logic [3:0] CYCLES_LABEL_LEN = 4'd7;
	localparam logic [3:0] INDEX_LEN = 4'd2;
	localparam logic [3:0] DATA_LEN = 4'd9;	// Colon and eight digits
	localparam logic [3:0] COUNT_LEN = 4'd4;

	// Fields of one line slot, in drawing order
	localparam logic [1:0] FIELD_INDEX = 2'd0;
	localparam logic [1:0] FIELD_DATA = 2'd1;
	localparam logic [1:0] FIELD_CYCLES = 2'd2;
	localparam logic [1:0] FIELD_PC = 2'd3;

endpackage

//--- run_sim.sh
#!/bin/sh
# Builds the character engine testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -Wno-fatal \
	--top-module char_engine_tb -f sources.f -o char_engine_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/char_engine_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "=== PASS ===" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed, see sim.log"
exit 1

//--- sim/char_engine_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent checks on the character engine ports, bound into char_engine
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module char_engine_assert (
	input logic clock,
	input logic reset,
	input logic [4:0] reg_sel,
	input logic mem_valid,
	input logic mem_ready,
	input screen_pkg::fb_addr_t mem_addr,
	input char_pkg::glyph_row_t mem_data
);

	localparam int FB_BYTES = screen_pkg::TEXT_ROWS * screen_pkg::ROW_PITCH;
	localparam int LAST_LINE = screen_pkg::GLYPH_FIRST_LINE + char_pkg::GLYPH_ROWS - 1;

	int reset_failures = 0;
	int hold_failures = 0;
	int range_failures = 0;
	int cell_line;	// Scan line inside the text cell

	assign cell_line = (int'(mem_addr) % screen_pkg::ROW_PITCH) / screen_pkg::LINE_BYTES;

	// Writer idle and slot 0 selected once reset lets go
	reset_state: assert property (@(posedge clock)
		reset |=> !mem_valid && (reg_sel == 5'd0))
	else begin
		reset_failures++;
		$error("mem_valid or reg_sel not cleared after reset");
	end

	write_hold: assert property (@(posedge clock) disable iff (reset)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_data))
	else begin
		hold_failures++;
		$error("frame buffer write changed while stalled");
	end

	write_range: assert property (@(posedge clock) disable iff (reset)
		mem_valid |-> (int'(mem_addr) < FB_BYTES)
			&& (cell_line >= screen_pkg::GLYPH_FIRST_LINE) && (cell_line <= LAST_LINE))
	else begin
		range_failures++;
		$error("frame buffer address %0d outside the glyph lines", mem_addr);
	end

endmodule

//--- sim/char_engine_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the character engine, models registers and PC, keeps a
// shadow frame buffer and compares the drawn cells with its own glyphs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module char_engine_tb;

	localparam int FB_BYTES = screen_pkg::TEXT_ROWS * screen_pkg::ROW_PITCH;
	localparam int WAIT_LIMIT = 20000;	// Cycles, about three passes
	localparam int COLON = 16;	// Local code after the hex digits
	localparam int BLANK = 17;	// Empty cell

	logic clock;
	logic reset;
	logic [4:0] reg_sel;
	screen_pkg::reg_word_t reg_data;
	screen_pkg::pc_word_t cycle_count;
	logic pc_strobe;
	screen_pkg::pc_word_t pc_value;
	logic mem_valid;
	logic mem_ready;
	screen_pkg::fb_addr_t mem_addr;
	char_pkg::glyph_row_t mem_data;

	screen_pkg::reg_word_t reg_model [screen_pkg::REG_COUNT];
	screen_pkg::pc_word_t hist_model [screen_pkg::PC_HIST_DEPTH];
	logic [7:0] shadow [FB_BYTES];
	int checks;
	int errors;
	int timeouts;

	tb_clock u_clock (
		.clock(clock),
		.reset(reset)
	);

	char_engine dut (
		.clock(clock),
		.reset(reset),
		.reg_sel(reg_sel),
		.reg_data(reg_data),
		.cycle_count(cycle_count),
		.pc_strobe(pc_strobe),
		.pc_value(pc_value),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

	bind char_engine char_engine_assert u_assert (
		.clock(clock),
		.reset(reset),
		.reg_sel(reg_sel),
		.mem_valid(mem_valid),
		.mem_ready(mem_ready),
		.mem_addr(mem_addr),
		.mem_data(mem_data)
	);

	assign reg_data = reg_model[reg_sel];	// Register file read

	always @(posedge clock) begin
		if (!reset && mem_valid && mem_ready && (int'(mem_addr) < FB_BYTES)) begin
			shadow[mem_addr] = mem_data;	// Handshake completes
		end
	end

	// Random back-pressure, ready three cycles out of four
	initial begin
		mem_ready = 1'b0;
		forever begin
			@(posedge clock);
			mem_ready <= ($urandom_range(3, 0) != 0);
		end
	end

	// Pixel row of a hex digit, the colon or a blank cell, top row is line 0
	function automatic logic [7:0] glyph_line(input int code, input int line);
		logic [63:0] rows;
		case (code)
			0: rows = 64'h3C42_4242_4242_423C;
			1: rows = 64'h1838_7818_1818_187E;
			2: rows = 64'h3C66_660C_1830_607E;
			3: rows = 64'h7C06_067C_0606_067C;
			4: rows = 64'h0E16_2646_467E_0606;
			5: rows = 64'h7E60_6078_0C06_0C78;
			6: rows = 64'h3C40_407C_4242_423C;
			7: rows = 64'h7E06_0606_0C18_3060;
			8: rows = 64'h3C42_423C_4242_423C;
			9: rows = 64'h3C46_4646_3E06_0606;
			10: rows = 64'h3C42_4242_7E42_4242;
			11: rows = 64'h7C42_467C_4642_427C;
			12: rows = 64'h3E60_6060_6060_603E;
			13: rows = 64'h7C62_6262_6262_627C;
			14: rows = 64'h3E60_607E_6060_603E;
			15: rows = 64'h7E60_607E_6060_6060;
			COLON: rows = 64'h0018_1800_0018_1800;
			default: rows = '0;
		endcase
		return rows[63 - 8 * line -: 8];
	endfunction

	task automatic end_run();
		int assert_fails;
		assert_fails = dut.u_assert.reset_failures + dut.u_assert.hold_failures
			+ dut.u_assert.range_failures;
		$display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
			checks, errors, timeouts, assert_fails);
		if ((errors == 0) && (timeouts == 0) && (assert_fails == 0)) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	endtask

	task automatic compare_cell(input int row, input int col, input int code);
		int addr;
		logic [7:0] expected;
		for (int line = 0; line < char_pkg::GLYPH_ROWS; line++) begin
			addr = row * screen_pkg::ROW_PITCH
				+ (screen_pkg::GLYPH_FIRST_LINE + line) * screen_pkg::LINE_BYTES + col;
			expected = glyph_line(code, line);
			checks++;
			assert (shadow[addr] === expected)
			else begin
				errors++;
				$display("error %0t: row %0d col %0d line %0d shows %h, expected %h",
					$time, row, col, line, shadow[addr], expected);
			end
		end
	endtask

	// Digits of a value, most significant nibble leftmost
	task automatic compare_hex(input int row, input int col, input logic [31:0] value,
		input int digits);
		for (int d = 0; d < digits; d++) begin
			compare_cell(row, col + d, int'((value >> (4 * (digits - 1 - d))) & 32'hF));
		end
	endtask

	task automatic label_cell_drawn(input int row, input int col);
		logic [7:0] pixels;
		pixels = '0;
		for (int line = 0; line < char_pkg::GLYPH_ROWS; line++) begin
			pixels |= shadow[row * screen_pkg::ROW_PITCH
				+ (screen_pkg::GLYPH_FIRST_LINE + line) * screen_pkg::LINE_BYTES + col];
		end
		checks++;
		assert (pixels != 8'h00)
		else begin
			errors++;
			$display("error %0t: label cell row %0d col %0d is blank", $time, row, col);
		end
	endtask

	task automatic check_registers();
		int row;
		for (int r = 0; r < screen_pkg::REG_COUNT; r++) begin
			row = screen_pkg::REG_FIRST_ROW + r;
			compare_hex(row, screen_pkg::REG_INDEX_COL, r, 2);
			compare_cell(row, screen_pkg::REG_DATA_COL, COLON);
			compare_hex(row, screen_pkg::REG_DATA_COL + 1, reg_model[r], 8);
		end
	endtask

	task automatic check_history();
		for (int k = 0; k < screen_pkg::PC_HIST_DEPTH; k++) begin
			compare_hex(screen_pkg::REG_FIRST_ROW + k, screen_pkg::PC_HIST_COL,
				hist_model[k], 4);
		end
		// Slots from 10 on draw no history entry
		for (int k = screen_pkg::PC_HIST_DEPTH; k < screen_pkg::REG_COUNT; k++) begin
			for (int d = 0; d < 4; d++) begin
				compare_cell(screen_pkg::REG_FIRST_ROW + k,
					screen_pkg::PC_HIST_COL + d, BLANK);
			end
		end
	endtask

	task automatic check_labels();
		for (int c = 0; c < screen_pkg::REGS_LABEL_LEN; c++) begin
			label_cell_drawn(screen_pkg::LABEL_ROW, screen_pkg::REGS_LABEL_COL + c);
		end
		for (int c = 0; c < screen_pkg::PC_LABEL_LEN; c++) begin
			if (c != 2) begin	// Space between PC and HISTORY
				label_cell_drawn(screen_pkg::LABEL_ROW, screen_pkg::PC_LABEL_COL + c);
			end
		end
		for (int c = 0; c < screen_pkg::CYCLES_LABEL_LEN; c++) begin
			label_cell_drawn(screen_pkg::CYCLES_LABEL_ROW, screen_pkg::CYCLES_LABEL_COL + c);
		end
	endtask

	// Every third strobe repeats the last value, one brings back an older one
	task automatic strobe_pcs();
		screen_pkg::pc_word_t value;
		value = '0;
		for (int i = 0; i < 16; i++) begin
			if ((i % 3) != 2) begin
				value = 16'($urandom());
			end
			if (i == 13) begin
				value = hist_model[3];
			end
			@(posedge clock);
			pc_strobe <= 1'b1;
			pc_value <= value;
			if (value != hist_model[0]) begin
				for (int k = screen_pkg::PC_HIST_DEPTH - 1; k > 0; k--) begin
					hist_model[k] = hist_model[k - 1];
				end
				hist_model[0] = value;
			end
			@(posedge clock);
			pc_strobe <= 1'b0;
		end
	endtask

	task automatic await_reset_release();
		int cycles;
		cycles = 0;
		while (reset && (cycles < WAIT_LIMIT)) begin
			@(negedge clock);
			cycles++;
		end
		if (reset) begin
			timeouts++;
			$display("Timed out waiting for reset to be released");
		end
	endtask

	task automatic await_slot(input logic [4:0] sel);
		int cycles;
		cycles = 0;
		while ((reg_sel !== sel) && (cycles < WAIT_LIMIT)) begin
			@(negedge clock);
			cycles++;
		end
		if (reg_sel !== sel) begin
			timeouts++;
			$display("Timed out waiting for the engine to reach slot %0d", sel);
		end
	endtask

	task automatic await_writer_idle();
		int cycles;
		cycles = 0;
		while (mem_valid && (cycles < WAIT_LIMIT)) begin
			@(negedge clock);
			cycles++;
		end
		if (mem_valid) begin
			timeouts++;
			$display("Timed out waiting for the frame buffer writes to drain");
		end
	endtask

	// Slot 31 done once the wrap to 0 is seen and its last glyph has drained
	task automatic await_pass_end();
		await_slot(5'd31);
		if (timeouts == 0) begin
			await_slot(5'd0);
		end
		if (timeouts == 0) begin
			await_writer_idle();
		end
	endtask

	initial begin
		void'($urandom(61));
		checks = 0;
		errors = 0;
		timeouts = 0;
		pc_strobe = 1'b0;
		pc_value = '0;
		cycle_count = 16'($urandom());
		for (int r = 0; r < screen_pkg::REG_COUNT; r++) begin
			reg_model[r] = $urandom();
		end
		for (int k = 0; k < screen_pkg::PC_HIST_DEPTH; k++) begin
			hist_model[k] = '0;
		end
		for (int a = 0; a < FB_BYTES; a++) begin
			shadow[a] = 8'h00;
		end
		await_reset_release();
		if (timeouts == 0) begin
			await_pass_end();
		end
		if (timeouts == 0) begin
			check_registers();
			compare_hex(screen_pkg::CYCLES_LABEL_ROW, screen_pkg::CYCLES_COL, cycle_count, 4);
			check_labels();
			strobe_pcs();
			@(posedge clock);
			cycle_count <= 16'($urandom());
			await_pass_end();	// Finishes the pass the strobes fell into
		end
		if (timeouts == 0) begin
			await_pass_end();
		end
		if (timeouts == 0) begin
			check_history();
			compare_hex(screen_pkg::CYCLES_LABEL_ROW, screen_pkg::CYCLES_COL, cycle_count, 4);
		end
		end_run();
	end

endmodule

//--- sim/tb_clock.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench clock of 4 ns and a reset held for the first 10 cycles
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module tb_clock (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;	// Released on a rising edge
	end

	always #2 clock = ~clock;	// Half of the 4 ns period

endmodule

//--- sources.f
design/char_pkg.sv
design/screen_pkg.sv
design/glyph_rom.sv
design/pc_history.sv
design/field_sequencer.sv
design/char_writer.sv
design/char_engine.sv
sim/tb_clock.sv
sim/char_engine_assert.sv
sim/char_engine_tb.sv
